// File: design/io_types_pkg.sv
package io_types_pkg;

   // *************************************************
   // Bus payload types
   // *************************************************

   typedef logic [31:0] wb_data_t;
   typedef logic [3:0]  wb_sel_t;
   typedef logic [3:0]  reg_idx_t;

   // Pin vectors for the two GPIO ports
   typedef logic [31:0] gpio_word_t;
   typedef logic [4:0]  btn_word_t;

   // Expand a byte select into a bit mask over the data word
   function automatic wb_data_t sel_to_mask(wb_sel_t sel);
      wb_data_t mask;
      for (int b = 0; b < $bits(wb_sel_t); b++) begin
         mask[8*b +: 8] = {8{sel[b]}};
      end
      return mask;
   endfunction

   // Byte-wise merge of new write data into an old word
   function automatic wb_data_t sel_merge(wb_data_t old_word, wb_data_t new_word, wb_sel_t sel);
      wb_data_t mask;
      mask = sel_to_mask(sel);
      return (old_word & ~mask) | (new_word & mask);
   endfunction

endpackage

// File: design/io_map_pkg.sv
package io_map_pkg;

   // *************************************************
   // Host address layout
   // *************************************************

   localparam int HOST_ADDR_W = 16;
   localparam int REGION_MSB  = 15;
   localparam int REGION_LSB  = 12;
   localparam int REG_IDX_LSB = 2;

   // Region codes in address bits 15:12
   localparam logic [REGION_MSB-REGION_LSB:0] REGION_GPIO = 4'd0;
   localparam logic [REGION_MSB-REGION_LSB:0] REGION_BTN  = 4'd1;
   localparam logic [REGION_MSB-REGION_LSB:0] REGION_SYS  = 4'd2;

   // *************************************************
   // Register indices
   // *************************************************

   localparam io_types_pkg::reg_idx_t GPIO_REG_IN   = 4'd0;
   localparam io_types_pkg::reg_idx_t GPIO_REG_OUT  = 4'd1;
   localparam io_types_pkg::reg_idx_t GPIO_REG_OE   = 4'd2;
   localparam io_types_pkg::reg_idx_t GPIO_REG_INTE = 4'd3;
   localparam io_types_pkg::reg_idx_t GPIO_REG_INTS = 4'd4;

   localparam io_types_pkg::reg_idx_t SYS_REG_MTIME    = 4'd0;
   localparam io_types_pkg::reg_idx_t SYS_REG_MTIMECMP = 4'd1;
   localparam io_types_pkg::reg_idx_t SYS_REG_IRQ_EN   = 4'd2;
   localparam io_types_pkg::reg_idx_t SYS_REG_IRQ_PEND = 4'd3;

   // Bit positions in IRQ_EN and IRQ_PEND
   localparam int IRQ_BIT_GPIO  = 0;
   localparam int IRQ_BIT_BTN   = 1;
   localparam int IRQ_BIT_TIMER = 2;

   // Timer compare starts out of reach
   localparam io_types_pkg::wb_data_t MTIMECMP_RESET = '1;

endpackage

// File: design/wb_if.sv
`timescale 1ns/10ps

interface wb_if;

   io_types_pkg::reg_idx_t idx;
   io_types_pkg::wb_data_t wdata;
   io_types_pkg::wb_data_t rdata;
   io_types_pkg::wb_sel_t  sel;
   logic                   we;
   logic                   cyc;
   logic                   stb;
   logic                   ack;
   logic                   err;

   // Bus controller side
   modport master (
      output idx, wdata, sel, we, cyc, stb,
      input  rdata, ack, err
   );

   // Register slave side
   modport slave (
      input  idx, wdata, sel, we, cyc, stb,
      output rdata, ack, err
   );

endinterface

// File: design/io_bus_ctrl.sv
`timescale 1ns/10ps

module io_bus_ctrl (
   input  logic                                   i_clk,
   input  logic                                   i_rst_n,
   input  logic                                   i_req_valid,
   input  logic                                   i_req_we,
   input  logic [io_map_pkg::HOST_ADDR_W-1:0]     i_req_addr,
   input  io_types_pkg::wb_data_t                 i_req_wdata,
   input  io_types_pkg::wb_sel_t                  i_req_sel,
   output logic                                   o_req_ready,
   output logic                                   o_rsp_valid,
   output logic                                   o_rsp_err,
   output io_types_pkg::wb_data_t                 o_rsp_rdata,
   wb_if.master                                   m_gpio,
   wb_if.master                                   m_btn,
   wb_if.master                                   m_sys
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUS,
      ST_RESP
   } state_t;

   state_t state_q;
   state_t state_d;

   logic [io_map_pkg::REGION_MSB-io_map_pkg::REGION_LSB:0] region_q;
   io_types_pkg::reg_idx_t idx_q;
   io_types_pkg::wb_data_t wdata_q;
   io_types_pkg::wb_sel_t  sel_q;
   logic                   we_q;

   logic                   accept;
   logic                   bus_act;
   logic                   hit_gpio;
   logic                   hit_btn;
   logic                   hit_sys;
   logic                   hit_any;
   logic                   miss_ack_q;
   logic                   done;
   io_types_pkg::wb_data_t ack_rdata;
   logic                   ack_err;

   assign o_req_ready = (state_q != ST_BUS);
   assign o_rsp_valid = (state_q == ST_RESP);
   assign accept      = i_req_valid & o_req_ready;
   assign bus_act     = (state_q == ST_BUS);

   // *************************************************
   // Region decode on the held request
   // *************************************************

   assign hit_gpio = (region_q == io_map_pkg::REGION_GPIO);
   assign hit_btn  = (region_q == io_map_pkg::REGION_BTN);
   assign hit_sys  = (region_q == io_map_pkg::REGION_SYS);
   assign hit_any  = hit_gpio | hit_btn | hit_sys;

   always_ff @(posedge i_clk) begin
      if (accept) begin
         region_q <= i_req_addr[io_map_pkg::REGION_MSB:io_map_pkg::REGION_LSB];
         idx_q    <= i_req_addr[io_map_pkg::REG_IDX_LSB +: $bits(io_types_pkg::reg_idx_t)];
         wdata_q  <= i_req_wdata;
         sel_q    <= i_req_sel;
         we_q     <= i_req_we;
      end
   end

   // Request fields are shared, only cyc and stb are per slave
   assign m_gpio.idx   = idx_q;
   assign m_gpio.wdata = wdata_q;
   assign m_gpio.sel   = sel_q;
   assign m_gpio.we    = we_q;
   assign m_gpio.cyc   = bus_act & hit_gpio;
   assign m_gpio.stb   = bus_act & hit_gpio;

   assign m_btn.idx    = idx_q;
   assign m_btn.wdata  = wdata_q;
   assign m_btn.sel    = sel_q;
   assign m_btn.we     = we_q;
   assign m_btn.cyc    = bus_act & hit_btn;
   assign m_btn.stb    = bus_act & hit_btn;

   assign m_sys.idx    = idx_q;
   assign m_sys.wdata  = wdata_q;
   assign m_sys.sel    = sel_q;
   assign m_sys.we     = we_q;
   assign m_sys.cyc    = bus_act & hit_sys;
   assign m_sys.stb    = bus_act & hit_sys;

   // Unmapped region answers itself with the same delay as a slave ack
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         miss_ack_q <= 1'b0;
      end else begin
         miss_ack_q <= bus_act & ~hit_any & ~miss_ack_q;
      end
   end

   always_comb begin
      ack_rdata = '0;
      ack_err   = 1'b0;
      done      = miss_ack_q;
      if (hit_gpio) begin
         ack_rdata = m_gpio.rdata;
         ack_err   = m_gpio.err;
         done      = m_gpio.ack;
      end else if (hit_btn) begin
         ack_rdata = m_btn.rdata;
         ack_err   = m_btn.err;
         done      = m_btn.ack;
      end else if (hit_sys) begin
         ack_rdata = m_sys.rdata;
         ack_err   = m_sys.err;
         done      = m_sys.ack;
      end else begin
         ack_err   = 1'b1;
      end
      done = done & bus_act;
   end

   // *************************************************
   // FSM and response capture
   // *************************************************

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: if (accept) state_d = ST_BUS;
         ST_BUS:  if (done) state_d = ST_RESP;
         ST_RESP: state_d = accept ? ST_BUS : ST_IDLE;
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge i_clk) begin
      if (done) begin
         o_rsp_rdata <= we_q ? '0 : ack_rdata;
         o_rsp_err   <= ack_err;
      end
   end

endmodule

// File: design/gpio_port.sv
`timescale 1ns/10ps

module gpio_port #(
   parameter type pins_t = io_types_pkg::gpio_word_t
) (
   input  logic  i_clk,
   input  logic  i_rst_n,
   wb_if.slave   s_bus,
   input  pins_t i_pins,
   output pins_t o_pins,
   output pins_t o_oe,
   output logic  o_irq
);

   pins_t out_q;
   pins_t oe_q;
   pins_t inte_q;
   pins_t ints_q;
   pins_t sync_q;
   pins_t in_q;
   pins_t in_d_q;
   pins_t rise;
   pins_t pin_wdata;
   pins_t pin_mask;
   pins_t ints_clr;

   logic                   ack_q;
   logic                   access;
   logic                   wr_en;
   io_types_pkg::wb_data_t wmask;
   io_types_pkg::wb_data_t rd_data;
   io_types_pkg::wb_data_t rdata_q;

   // *************************************************
   // Bus access
   // *************************************************

   assign access    = s_bus.cyc & s_bus.stb & ~ack_q;
   assign wr_en     = access & s_bus.we;
   assign wmask     = io_types_pkg::sel_to_mask(s_bus.sel);
   assign pin_mask  = pins_t'(wmask);
   assign pin_wdata = pins_t'(s_bus.wdata & wmask);

   assign s_bus.ack   = ack_q;
   assign s_bus.rdata = rdata_q;
   assign s_bus.err   = 1'b0;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_comb begin
      case (s_bus.idx)
         io_map_pkg::GPIO_REG_IN:   rd_data = io_types_pkg::wb_data_t'(in_q);
         io_map_pkg::GPIO_REG_OUT:  rd_data = io_types_pkg::wb_data_t'(out_q);
         io_map_pkg::GPIO_REG_OE:   rd_data = io_types_pkg::wb_data_t'(oe_q);
         io_map_pkg::GPIO_REG_INTE: rd_data = io_types_pkg::wb_data_t'(inte_q);
         io_map_pkg::GPIO_REG_INTS: rd_data = io_types_pkg::wb_data_t'(ints_q);
         default:                   rd_data = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (access) begin
         rdata_q <= rd_data;
      end
   end

   // *************************************************
   // Pin registers
   // *************************************************

   // Two-flop synchronizer, then one more stage for edge detect
   assign rise     = in_q & ~in_d_q;
   assign ints_clr = (wr_en && s_bus.idx == io_map_pkg::GPIO_REG_INTS) ? pin_wdata : '0;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_q  <= '0;
         oe_q   <= '0;
         inte_q <= '0;
         ints_q <= '0;
         sync_q <= '0;
         in_q   <= '0;
         in_d_q <= '0;
      end else begin
         sync_q <= i_pins;
         in_q   <= sync_q;
         in_d_q <= in_q;
         // Write one clears, a new edge in the same cycle wins
         ints_q <= (ints_q & ~ints_clr) | rise;
         if (wr_en) begin
            case (s_bus.idx)
               io_map_pkg::GPIO_REG_OUT:  out_q  <= (out_q & ~pin_mask) | pin_wdata;
               io_map_pkg::GPIO_REG_OE:   oe_q   <= (oe_q & ~pin_mask) | pin_wdata;
               io_map_pkg::GPIO_REG_INTE: inte_q <= (inte_q & ~pin_mask) | pin_wdata;
               default: ;
            endcase
         end
      end
   end

   assign o_pins = out_q;
   assign o_oe   = oe_q;
   assign o_irq  = |(ints_q & inte_q);

endmodule

// File: design/sys_con.sv
`timescale 1ns/10ps

module sys_con (
   input  logic i_clk,
   input  logic i_rst_n,
   wb_if.slave  s_bus,
   input  logic i_gpio_irq,
   input  logic i_btn_irq,
   output logic o_irq,
   output logic o_timer_irq
);

   io_types_pkg::wb_data_t mtime_q;
   io_types_pkg::wb_data_t mtimecmp_q;
   io_types_pkg::wb_data_t rd_data;
   io_types_pkg::wb_data_t rdata_q;

   logic [2:0] irq_en_q;
   logic [2:0] pending;
   logic       timer_hit;
   logic       ack_q;
   logic       access;
   logic       wr_en;

   assign access = s_bus.cyc & s_bus.stb & ~ack_q;
   assign wr_en  = access & s_bus.we;

   assign s_bus.ack   = ack_q;
   assign s_bus.rdata = rdata_q;
   assign s_bus.err   = 1'b0;

   // Live interrupt sources
   assign timer_hit                       = (mtime_q >= mtimecmp_q);
   assign pending[io_map_pkg::IRQ_BIT_GPIO]  = i_gpio_irq;
   assign pending[io_map_pkg::IRQ_BIT_BTN]   = i_btn_irq;
   assign pending[io_map_pkg::IRQ_BIT_TIMER] = timer_hit;

   always_comb begin
      case (s_bus.idx)
         io_map_pkg::SYS_REG_MTIME:    rd_data = mtime_q;
         io_map_pkg::SYS_REG_MTIMECMP: rd_data = mtimecmp_q;
         io_map_pkg::SYS_REG_IRQ_EN:   rd_data = {29'd0, irq_en_q};
         io_map_pkg::SYS_REG_IRQ_PEND: rd_data = {29'd0, pending};
         default:                      rd_data = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (access) begin
         rdata_q <= rd_data;
      end
   end

   // *************************************************
   // Timer and interrupt registers
   // *************************************************

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q       <= 1'b0;
         mtime_q     <= '0;
         mtimecmp_q  <= io_map_pkg::MTIMECMP_RESET;
         irq_en_q    <= '0;
         o_irq       <= 1'b0;
         o_timer_irq <= 1'b0;
      end else begin
         ack_q       <= access;
         o_timer_irq <= timer_hit;
         o_irq       <= |(pending & irq_en_q);
         // A write to mtime replaces the count for that cycle
         if (wr_en && s_bus.idx == io_map_pkg::SYS_REG_MTIME) begin
            mtime_q <= io_types_pkg::sel_merge(mtime_q, s_bus.wdata, s_bus.sel);
         end else begin
            mtime_q <= mtime_q + 1'b1;
         end
         if (wr_en && s_bus.idx == io_map_pkg::SYS_REG_MTIMECMP) begin
            mtimecmp_q <= io_types_pkg::sel_merge(mtimecmp_q, s_bus.wdata, s_bus.sel);
         end
         if (wr_en && s_bus.idx == io_map_pkg::SYS_REG_IRQ_EN && s_bus.sel[0]) begin
            irq_en_q <= s_bus.wdata[2:0];
         end
      end
   end

endmodule

// File: design/io_subsys_top.sv
`timescale 1ns/10ps

module io_subsys_top (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_req_valid,
   input  logic                   i_req_we,
   input  logic [15:0]            i_req_addr,
   input  io_types_pkg::wb_data_t i_req_wdata,
   input  io_types_pkg::wb_sel_t  i_req_sel,
   output logic                   o_req_ready,
   output logic                   o_rsp_valid,
   output logic                   o_rsp_err,
   output io_types_pkg::wb_data_t o_rsp_rdata,
   inout  wire [31:0]             io_data,
   inout  wire [4:0]              io_data_btn,
   output logic                   o_irq,
   output logic                   o_timer_irq
);

   io_types_pkg::gpio_word_t gpio_in;
   io_types_pkg::gpio_word_t gpio_out;
   io_types_pkg::gpio_word_t gpio_oe;
   io_types_pkg::btn_word_t  btn_in;
   io_types_pkg::btn_word_t  btn_out;
   io_types_pkg::btn_word_t  btn_oe;
   logic                     gpio_irq;
   logic                     btn_irq;

   wb_if wb_gpio ();
   wb_if wb_btn ();
   wb_if wb_sys ();

   io_bus_ctrl u_bus_ctrl (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_req_valid (i_req_valid),
      .i_req_we    (i_req_we),
      .i_req_addr  (i_req_addr),
      .i_req_wdata (i_req_wdata),
      .i_req_sel   (i_req_sel),
      .o_req_ready (o_req_ready),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp_err   (o_rsp_err),
      .o_rsp_rdata (o_rsp_rdata),
      .m_gpio      (wb_gpio),
      .m_btn       (wb_btn),
      .m_sys       (wb_sys)
   );

   // LEDs and switches
   gpio_port #(.pins_t(io_types_pkg::gpio_word_t)) u_gpio (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .s_bus   (wb_gpio),
      .i_pins  (gpio_in),
      .o_pins  (gpio_out),
      .o_oe    (gpio_oe),
      .o_irq   (gpio_irq)
   );

   // Push buttons
   gpio_port #(.pins_t(io_types_pkg::btn_word_t)) u_btn (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .s_bus   (wb_btn),
      .i_pins  (btn_in),
      .o_pins  (btn_out),
      .o_oe    (btn_oe),
      .o_irq   (btn_irq)
   );

   sys_con u_sys_con (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .s_bus       (wb_sys),
      .i_gpio_irq  (gpio_irq),
      .i_btn_irq   (btn_irq),
      .o_irq       (o_irq),
      .o_timer_irq (o_timer_irq)
   );

   // *************************************************
   // Tri-state pads
   // *************************************************

   for (genvar i = 0; i < $bits(io_types_pkg::gpio_word_t); i++) begin : g_gpio_pad
      assign io_data[i] = gpio_oe[i] ? gpio_out[i] : 1'bz;
   end

   for (genvar i = 0; i < $bits(io_types_pkg::btn_word_t); i++) begin : g_btn_pad
      assign io_data_btn[i] = btn_oe[i] ? btn_out[i] : 1'bz;
   end

   // Pads read back their own level
   assign gpio_in = io_data;
   assign btn_in  = io_data_btn;

endmodule

// File: dv/io_subsys_properties.sv
`timescale 1ns/10ps

module io_subsys_properties (
   input logic i_clk,
   input logic i_rst_n,
   input logic i_req_valid,
   input logic o_req_ready,
   input logic o_rsp_valid,
   input logic gpio_stb,
   input logic gpio_ack,
   input logic btn_stb,
   input logic btn_ack,
   input logic sys_stb,
   input logic sys_ack
);

   int   fail_count;
   logic accept;

   initial fail_count = 0;

   assign accept = i_req_valid & o_req_ready;

   // *************************************************
   // Wishbone slave handshake
   // *************************************************

   property p_ack_next(stb, ack);
      @(posedge i_clk) disable iff (!i_rst_n)
      (stb && !ack) |=> ack;
   endproperty

   property p_ack_after_stb(stb, ack);
      @(posedge i_clk) disable iff (!i_rst_n)
      ack |-> $past(stb && !ack);
   endproperty

   a_one_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $onehot0({gpio_stb, btn_stb, sys_stb}))
      else begin fail_count++; $error("more than one slave strobe is high"); end

   a_gpio_ack: assert property (p_ack_next(gpio_stb, gpio_ack))
      else begin fail_count++; $error("gpio ack missing one cycle after stb"); end
   a_btn_ack: assert property (p_ack_next(btn_stb, btn_ack))
      else begin fail_count++; $error("button ack missing one cycle after stb"); end
   a_sys_ack: assert property (p_ack_next(sys_stb, sys_ack))
      else begin fail_count++; $error("sys_con ack missing one cycle after stb"); end

   a_gpio_ack_src: assert property (p_ack_after_stb(gpio_stb, gpio_ack))
      else begin fail_count++; $error("gpio ack without a preceding stb"); end
   a_btn_ack_src: assert property (p_ack_after_stb(btn_stb, btn_ack))
      else begin fail_count++; $error("button ack without a preceding stb"); end
   a_sys_ack_src: assert property (p_ack_after_stb(sys_stb, sys_ack))
      else begin fail_count++; $error("sys_con ack without a preceding stb"); end

   // *************************************************
   // Host port timing
   // *************************************************

   // Valid rises at the second edge after acceptance
   a_rsp_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      accept |=> !o_rsp_valid ##1 !o_rsp_valid ##1 o_rsp_valid)
      else begin fail_count++; $error("response not two cycles after acceptance"); end

   a_busy_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      accept |=> !o_req_ready ##1 !o_req_ready ##1 o_req_ready)
      else begin fail_count++; $error("request ready while a transaction is busy"); end

endmodule

bind io_bus_ctrl io_subsys_properties u_props (
   .i_clk       (i_clk),
   .i_rst_n     (i_rst_n),
   .i_req_valid (i_req_valid),
   .o_req_ready (o_req_ready),
   .o_rsp_valid (o_rsp_valid),
   .gpio_stb    (m_gpio.stb),
   .gpio_ack    (m_gpio.ack),
   .btn_stb     (m_btn.stb),
   .btn_ack     (m_btn.ack),
   .sys_stb     (m_sys.stb),
   .sys_ack     (m_sys.ack)
);

// File: dv/tb_io_subsys.sv
`timescale 1ns/10ps

module tb_io_subsys;

   localparam int MAX_OPS   = 64;
   localparam int TD_FIELDS = 6;

   // Operation codes in the first column of the test data
   localparam logic [31:0] OP_WRITE = 32'h1;
   localparam logic [31:0] OP_READ  = 32'h2;
   localparam logic [31:0] OP_PAD   = 32'h3;
   localparam logic [31:0] OP_WAIT  = 32'h4;
   localparam logic [31:0] OP_IRQ   = 32'h5;
   localparam logic [31:0] OP_PADCK = 32'h6;
   localparam logic [31:0] OP_END   = 32'hf;

   logic        i_clk;
   logic        i_rst_n;
   logic        i_req_valid;
   logic        i_req_we;
   logic [15:0] i_req_addr;
   logic [31:0] i_req_wdata;
   logic [3:0]  i_req_sel;
   logic        o_req_ready;
   logic        o_rsp_valid;
   logic        o_rsp_err;
   logic [31:0] o_rsp_rdata;
   logic        o_irq;
   logic        o_timer_irq;
   wire  [31:0] io_data;
   wire  [4:0]  io_data_btn;

   logic [31:0] gpio_drv_val;
   logic [31:0] gpio_drv_en;
   logic [4:0]  btn_drv_val;
   logic [4:0]  btn_drv_en;

   logic [31:0] tdata [0:MAX_OPS*TD_FIELDS-1];
   int          cycle_cnt = 0;
   int          cycle_limit;

   io_subsys_top dut0 (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_req_valid (i_req_valid),
      .i_req_we    (i_req_we),
      .i_req_addr  (i_req_addr),
      .i_req_wdata (i_req_wdata),
      .i_req_sel   (i_req_sel),
      .o_req_ready (o_req_ready),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp_err   (o_rsp_err),
      .o_rsp_rdata (o_rsp_rdata),
      .io_data     (io_data),
      .io_data_btn (io_data_btn),
      .o_irq       (o_irq),
      .o_timer_irq (o_timer_irq)
   );

   // Pad drivers, only enabled pins are driven
   for (genvar i = 0; i < 32; i++) begin : g_gpio_drv
      assign io_data[i] = gpio_drv_en[i] ? gpio_drv_val[i] : 1'bz;
   end

   for (genvar i = 0; i < 5; i++) begin : g_btn_drv
      assign io_data_btn[i] = btn_drv_en[i] ? btn_drv_val[i] : 1'bz;
   end

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout after %0d cycles, the test data did not complete", cycle_cnt);
         end_with_failure();
      end
   end

   // *************************************************
   // Helper tasks
   // *************************************************

   task end_with_failure();
      $display("Simulation finished: FAIL");
      $fatal(1, "Run stopped on the first failure");
   endtask

   task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   task automatic host_access(input logic we, input logic [15:0] addr,
                              input logic [31:0] wdata, input logic [3:0] sel,
                              output logic [31:0] rdata, output logic err);
      int wait_cnt;
      @(negedge i_clk);
      while (!o_req_ready) @(negedge i_clk);
      i_req_valid = 1'b1;
      i_req_we    = we;
      i_req_addr  = addr;
      i_req_wdata = wdata;
      i_req_sel   = sel;
      @(negedge i_clk);
      i_req_valid = 1'b0;
      wait_cnt    = 1;
      while (!o_rsp_valid) begin
         if (wait_cnt > 8) begin
            $display("No response from the DUT within 8 cycles of request to %h", addr);
            end_with_failure();
         end
         check_value({31'd0, o_req_ready}, 32'd0, "req_ready while busy");
         @(negedge i_clk);
         wait_cnt++;
      end
      check_value({31'd0, o_req_ready}, 32'd1, "req_ready in the response cycle");
      rdata = o_rsp_rdata;
      err   = o_rsp_err;
   endtask

   // *************************************************
   // Test sequence
   // *************************************************

   initial begin
      int          op_count;
      int          wait_sum;
      int          op_idx;
      logic [31:0] op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] sel;
      logic [31:0] exp;
      logic [31:0] exp_err;
      logic [31:0] rdata;
      logic        rerr;

      i_rst_n      = 1'b0;
      i_req_valid  = 1'b0;
      i_req_we     = 1'b0;
      i_req_addr   = '0;
      i_req_wdata  = '0;
      i_req_sel    = '0;
      gpio_drv_val = '0;
      gpio_drv_en  = '0;
      btn_drv_val  = '0;
      btn_drv_en   = '0;

      $readmemh("dv/io_testdata.txt", tdata);
      op_count = 0;
      wait_sum = 0;
      while (op_count < MAX_OPS && tdata[TD_FIELDS*op_count] !== OP_END) begin
         if (tdata[TD_FIELDS*op_count] === OP_WAIT) begin
            wait_sum += tdata[TD_FIELDS*op_count+2];
         end
         op_count++;
      end
      cycle_limit = wait_sum + 4*op_count + 4 + 64;
      if (op_count == MAX_OPS) begin
         $display("The test data has no end marker");
         end_with_failure();
      end

      repeat (4) @(posedge i_clk);
      @(negedge i_clk);
      i_rst_n = 1'b1;

      for (op_idx = 0; op_idx < op_count; op_idx++) begin
         op      = tdata[TD_FIELDS*op_idx];
         addr    = tdata[TD_FIELDS*op_idx+1];
         data    = tdata[TD_FIELDS*op_idx+2];
         sel     = tdata[TD_FIELDS*op_idx+3];
         exp     = tdata[TD_FIELDS*op_idx+4];
         exp_err = tdata[TD_FIELDS*op_idx+5];
         case (op)
            OP_WRITE, OP_READ: begin
               host_access(op == OP_WRITE, addr[15:0], data, sel[3:0], rdata, rerr);
               check_value(rdata, exp, $sformatf("line %0d rdata at %h", op_idx, addr[15:0]));
               check_value({31'd0, rerr}, exp_err, $sformatf("line %0d rsp_err", op_idx));
            end
            OP_PAD: begin
               @(negedge i_clk);
               if (addr[0]) begin
                  btn_drv_val = data[4:0];
                  btn_drv_en  = exp[4:0];
               end else begin
                  gpio_drv_val = data;
                  gpio_drv_en  = exp;
               end
            end
            OP_WAIT: begin
               repeat (data) @(negedge i_clk);
            end
            OP_IRQ: begin
               @(negedge i_clk);
               check_value({30'd0, o_timer_irq, o_irq}, exp,
                           $sformatf("line %0d {timer_irq, irq}", op_idx));
            end
            OP_PADCK: begin
               @(negedge i_clk);
               check_value(addr[0] ? {27'd0, io_data_btn} : io_data, exp,
                           $sformatf("line %0d pad level", op_idx));
            end
            default: begin
               $display("Unknown operation %h on test data line %0d", op, op_idx);
               end_with_failure();
            end
         endcase
      end

      repeat (2) @(negedge i_clk);
      if (dut0.u_bus_ctrl.u_props.fail_count == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("%0d bus assertion failures were reported",
                  dut0.u_bus_ctrl.u_props.fail_count);
         end_with_failure();
      end
   end

endmodule

// File: src.f
design/io_types_pkg.sv
design/io_map_pkg.sv
design/wb_if.sv
design/io_bus_ctrl.sv
design/gpio_port.sv
design/sys_con.sv
design/io_subsys_top.sv
dv/io_subsys_properties.sv
dv/tb_io_subsys.sv

// File: dv/io_testdata.txt
// op addr data sel exp err: op 1 write, 2 read, 3 pad drive, 4 wait, 5 irq check, 6 pad check, f end
// pad ops use addr as bank (0 gpio, 1 buttons) and exp as drive enable or pad level; irq exp is {timer, irq}
// State after reset
5 0000 00000000 0 00000000 0
6 0000 00000000 0 zzzzzzzz 0
2 0008 00000000 f 00000000 0
2 2004 00000000 f ffffffff 0
// GPIO output and readback
1 0004 a5a5a55a f 00000000 0
1 0008 000000ff f 00000000 0
6 0000 00000000 0 zzzzzz5a 0
2 0004 00000000 f a5a5a55a 0
2 0008 00000000 f 000000ff 0
// Byte select writes to OUT
1 0004 12345678 5 00000000 0
2 0004 00000000 f a534a578 0
6 0000 00000000 0 zzzzzz78 0
1 0004 deadbeef a 00000000 0
2 0004 00000000 f de34be78 0
// Button input and edge interrupt
3 0001 0000001e 0 0000001f 0
4 0000 00000005 0 00000000 0
1 1010 0000001f f 00000000 0
1 100c 00000001 f 00000000 0
1 2008 00000002 f 00000000 0
5 0000 00000000 0 00000000 0
3 0001 0000001f 0 0000001f 0
4 0000 00000005 0 00000000 0
2 1000 00000000 f 0000001f 0
2 1010 00000000 f 00000001 0
2 200c 00000000 f 00000002 0
5 0000 00000000 0 00000001 0
1 1010 00000001 f 00000000 0
5 0000 00000000 0 00000000 0
2 1010 00000000 f 00000000 0
// Machine timer compare
1 2004 ffffffff f 00000000 0
1 2000 00000000 f 00000000 0
1 2004 00000028 f 00000000 0
5 0000 00000000 0 00000000 0
4 0000 00000014 0 00000000 0
5 0000 00000000 0 00000000 0
4 0000 0000001e 0 00000000 0
5 0000 00000000 0 00000002 0
2 200c 00000000 f 00000004 0
1 2004 ffffffff f 00000000 0
5 0000 00000000 0 00000000 0
// Unmapped region and unused indices
2 5000 00000000 f 00000000 1
1 5004 12345678 f 00000000 1
2 001c 00000000 f 00000000 0
1 0018 ffffffff f 00000000 0
2 0018 00000000 f 00000000 0
2 2010 00000000 f 00000000 0
f 0000 00000000 0 00000000 0
